// File: logic/gat_pkg.sv
`default_nettype none

package gat_pkg;

  // Problem scale
  localparam int NUM_FEAT_IN  = 16;
  localparam int NUM_FEAT_OUT = 4;
  localparam int MAX_NODES    = 8;

  // Datapath widths
  localparam int DATA_W      = 8;
  localparam int COL_IDX_W   = $clog2(NUM_FEAT_IN);
  localparam int ROW_LEN_W   = $clog2(NUM_FEAT_IN) + 1;
  localparam int NUM_NODE_W  = $clog2(MAX_NODES) + 1;
  localparam int FEAT_OUT_W  = $clog2(NUM_FEAT_OUT);
  localparam int SUBGRAPH_W  = 12;
  localparam int WH_DATA_W   = 20;
  localparam int COEF_W      = 32;
  localparam int LEAKY_SHIFT = 3;

  // Weight stream layout, W first then a_left and a_right
  localparam int W_WORDS   = NUM_FEAT_IN * NUM_FEAT_OUT;
  localparam int A_WORDS   = 2 * NUM_FEAT_OUT;
  localparam int WGT_CNT_W = $clog2(W_WORDS + A_WORDS + 1);

  typedef logic signed [DATA_W-1:0]    data_t;
  typedef logic signed [WH_DATA_W-1:0] wh_elem_t;

  // One weight row, also used for each half of a
  typedef data_t [NUM_FEAT_OUT-1:0] feat_vec_t;
  typedef feat_vec_t [NUM_FEAT_IN-1:0] w_mat_t;

  typedef struct packed {
    logic [5:0]            pad;
    logic                  is_target;
    logic [NUM_NODE_W-1:0] num_nodes;
    logic [ROW_LEN_W-1:0]  row_len;
  } h_hdr_t;

  typedef struct packed {
    logic [3:0]           pad;
    logic [COL_IDX_W-1:0] col;
    data_t                val;
  } h_nz_t;

  // Same H word seen as a row header or as a nonzero entry
  typedef union packed {
    h_hdr_t hdr;
    h_nz_t  nz;
  } h_word_u;

  typedef struct packed {
    logic    is_hdr;
    h_word_u word;
  } h_beat_t;

  typedef wh_elem_t [NUM_FEAT_OUT-1:0] wh_vec_t;

  typedef struct packed {
    wh_vec_t               wh;
    logic                  is_target;
    logic [NUM_NODE_W-1:0] num_nodes;
  } wh_rec_t;

  typedef struct packed {
    logic signed [COEF_W-1:0] score;
    logic [SUBGRAPH_W-1:0]    subgraph;
    logic [NUM_NODE_W-1:0]    node;
  } coef_rec_t;

endpackage

`default_nettype wire

// File: logic/weight_store.sv
`default_nettype none

module weight_store (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              wgt_stb_i,
  input  gat_pkg::data_t    wgt_data_i,

  output logic              w_rdy_o,
  output gat_pkg::w_mat_t   w_mat_o,
  output gat_pkg::feat_vec_t a_left_o,
  output gat_pkg::feat_vec_t a_right_o
);

  logic [gat_pkg::WGT_CNT_W-1:0] wgt_cnt;
  logic                          wgt_take;
  logic                          in_w;
  logic                          in_a_left;
  logic [gat_pkg::COL_IDX_W-1:0] w_row;
  logic [gat_pkg::FEAT_OUT_W-1:0] w_col;

  // Loading ends once every W and a word is in
  assign w_rdy_o  = (wgt_cnt == gat_pkg::W_WORDS + gat_pkg::A_WORDS);
  assign wgt_take = wgt_stb_i && !w_rdy_o;

  always_comb begin
    in_w      = (wgt_cnt < gat_pkg::W_WORDS);
    in_a_left = (wgt_cnt < gat_pkg::W_WORDS + gat_pkg::NUM_FEAT_OUT);
    // Row-major, so the low bits pick the output feature
    w_col     = wgt_cnt[gat_pkg::FEAT_OUT_W-1:0];
    w_row     = wgt_cnt[gat_pkg::FEAT_OUT_W +: gat_pkg::COL_IDX_W];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wgt_cnt <= '0;
    end else if (wgt_take) begin
      wgt_cnt <= wgt_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wgt_take) begin
      if (in_w) begin
        w_mat_o[w_row][w_col] <= wgt_data_i;
      end else if (in_a_left) begin
        a_left_o[w_col] <= wgt_data_i;
      end else begin
        a_right_o[w_col] <= wgt_data_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/spmm_row.sv
`default_nettype none

module spmm_row (
  input  logic             clk,
  input  logic             rst_n,

  input  logic             w_rdy_i,
  input  gat_pkg::w_mat_t  w_mat_i,

  input  logic             h_stb_i,
  input  gat_pkg::h_beat_t h_i,

  output logic             wh_stb_o,
  output gat_pkg::wh_rec_t wh_o
);

  logic [gat_pkg::ROW_LEN_W-1:0]  rem_q;
  logic                           tgt_q;
  logic [gat_pkg::NUM_NODE_W-1:0] nn_q;
  gat_pkg::wh_vec_t               acc_q;
  gat_pkg::wh_vec_t               acc_nxt;

  gat_pkg::h_hdr_t    hdr;
  gat_pkg::h_nz_t     nz;
  gat_pkg::feat_vec_t w_row;
  logic               beat_ok;
  logic               hdr_beat;
  logic               nz_beat;
  logic               last_nz;
  logic               empty_row;

  always_comb begin
    hdr       = h_i.word.hdr;
    nz        = h_i.word.nz;
    w_row     = w_mat_i[nz.col];
    // No H beat counts before the weights are in
    beat_ok   = h_stb_i && w_rdy_i;
    hdr_beat  = beat_ok && h_i.is_hdr;
    // Stray entries outside a row are dropped
    nz_beat   = beat_ok && !h_i.is_hdr && (rem_q != '0);
    last_nz   = nz_beat && (rem_q == 1);
    empty_row = hdr_beat && (hdr.row_len == '0);
  end

  // One MAC per output feature, all in the same cycle
  always_comb begin
    for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
      acc_nxt[f] = acc_q[f] + nz.val * w_row[f];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rem_q    <= '0;
      wh_stb_o <= 1'b0;
    end else begin
      if (hdr_beat) begin
        rem_q <= hdr.row_len;
      end else if (nz_beat) begin
        rem_q <= rem_q - 1'b1;
      end
      wh_stb_o <= empty_row || last_nz;
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_beat) begin
      acc_q <= '0;
      tgt_q <= hdr.is_target;
      nn_q  <= hdr.num_nodes;
    end else if (nz_beat) begin
      acc_q <= acc_nxt;
    end

    if (empty_row) begin
      wh_o.wh        <= '0;
      wh_o.is_target <= hdr.is_target;
      wh_o.num_nodes <= hdr.num_nodes;
    end else if (last_nz) begin
      wh_o.wh        <= acc_nxt;
      wh_o.is_target <= tgt_q;
      wh_o.num_nodes <= nn_q;
    end
  end

endmodule

`default_nettype wire

// File: logic/attn_coef.sv
`default_nettype none

module attn_coef (
  input  logic               clk,
  input  logic               rst_n,

  input  gat_pkg::feat_vec_t a_left_i,
  input  gat_pkg::feat_vec_t a_right_i,

  input  logic               wh_stb_i,
  input  gat_pkg::wh_rec_t   wh_i,

  output logic               coef_stb_o,
  output gat_pkg::coef_rec_t coef_o
);

  logic signed [gat_pkg::COEF_W-1:0] left_dot;
  logic signed [gat_pkg::COEF_W-1:0] right_dot;

  // Target state kept for the rest of the subgraph
  logic signed [gat_pkg::COEF_W-1:0] left_sv;
  logic [gat_pkg::SUBGRAPH_W-1:0]    sg_q;
  logic [gat_pkg::NUM_NODE_W-1:0]    node_q;

  logic                              s1_vld;
  logic signed [gat_pkg::COEF_W-1:0] s1_left;
  logic signed [gat_pkg::COEF_W-1:0] s1_right;
  logic [gat_pkg::SUBGRAPH_W-1:0]    s1_sg;
  logic [gat_pkg::NUM_NODE_W-1:0]    s1_node;

  logic signed [gat_pkg::COEF_W-1:0] e_sum;
  logic signed [gat_pkg::COEF_W-1:0] e_act;

  always_comb begin
    left_dot  = '0;
    right_dot = '0;
    for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
      left_dot  = left_dot + a_left_i[f] * wh_i.wh[f];
      right_dot = right_dot + a_right_i[f] * wh_i.wh[f];
    end
  end

  // Stage 1 control and indices
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
      // All ones so the first target wraps to subgraph 0
      sg_q   <= '1;
      node_q <= '0;
    end else begin
      s1_vld <= wh_stb_i;
      if (wh_stb_i) begin
        if (wh_i.is_target) begin
          sg_q   <= sg_q + 1'b1;
          node_q <= '0;
        end else begin
          node_q <= node_q + 1'b1;
        end
      end
    end
  end

  // Stage 1 payload
  always_ff @(posedge clk) begin
    if (wh_stb_i) begin
      s1_right <= right_dot;
      if (wh_i.is_target) begin
        left_sv <= left_dot;
        s1_left <= left_dot;
        s1_sg   <= sg_q + 1'b1;
        s1_node <= '0;
      end else begin
        s1_left <= left_sv;
        s1_sg   <= sg_q;
        s1_node <= node_q + 1'b1;
      end
    end
  end

  // LeakyReLU with a slope of 1/8 below zero
  always_comb begin
    e_sum = s1_left + s1_right;
    if (e_sum < 0) begin
      e_act = e_sum >>> gat_pkg::LEAKY_SHIFT;
    end else begin
      e_act = e_sum;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_stb_o <= 1'b0;
    end else begin
      coef_stb_o <= s1_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld) begin
      coef_o.score    <= e_act;
      coef_o.subgraph <= s1_sg;
      coef_o.node     <= s1_node;
    end
  end

endmodule

`default_nettype wire

// File: logic/gat_coef_top.sv
`default_nettype none

module gat_coef_top (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               wgt_stb_i,
  input  gat_pkg::data_t     wgt_data_i,

  input  logic               h_stb_i,
  input  gat_pkg::h_beat_t   h_i,

  output logic               w_rdy_o,

  output logic               wh_stb_o,
  output gat_pkg::wh_rec_t   wh_o,

  output logic               coef_stb_o,
  output gat_pkg::coef_rec_t coef_o
);

  gat_pkg::w_mat_t    w_mat;
  gat_pkg::feat_vec_t a_left;
  gat_pkg::feat_vec_t a_right;

  weight_store u_weight_store (
    .clk        (clk        ),
    .rst_n      (rst_n      ),
    .wgt_stb_i  (wgt_stb_i  ),
    .wgt_data_i (wgt_data_i ),
    .w_rdy_o    (w_rdy_o    ),
    .w_mat_o    (w_mat      ),
    .a_left_o   (a_left     ),
    .a_right_o  (a_right    )
  );

  // Wh records leave the chip and feed the score stage
  spmm_row u_spmm_row (
    .clk        (clk        ),
    .rst_n      (rst_n      ),
    .w_rdy_i    (w_rdy_o    ),
    .w_mat_i    (w_mat      ),
    .h_stb_i    (h_stb_i    ),
    .h_i        (h_i        ),
    .wh_stb_o   (wh_stb_o   ),
    .wh_o       (wh_o       )
  );

  attn_coef u_attn_coef (
    .clk        (clk        ),
    .rst_n      (rst_n      ),
    .a_left_i   (a_left     ),
    .a_right_i  (a_right    ),
    .wh_stb_i   (wh_stb_o   ),
    .wh_i       (wh_o       ),
    .coef_stb_o (coef_stb_o ),
    .coef_o     (coef_o     )
  );

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
`default_nettype none

module clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/gat_tb.sv
`default_nettype none

module gat_tb;

  logic                 clk;
  logic                 rst_n;
  logic                 wgt_stb_i;
  gat_pkg::data_t       wgt_data_i;
  logic                 h_stb_i;
  gat_pkg::h_beat_t     h_i;
  logic                 w_rdy_o;
  logic                 wh_stb_o;
  gat_pkg::wh_rec_t     wh_o;
  logic                 coef_stb_o;
  gat_pkg::coef_rec_t   coef_o;

  // Reference weights and model state
  int w_m [gat_pkg::NUM_FEAT_IN][gat_pkg::NUM_FEAT_OUT];
  int a_l [gat_pkg::NUM_FEAT_OUT];
  int a_r [gat_pkg::NUM_FEAT_OUT];
  int mdl_left;
  int mdl_sg;
  int mdl_node;

  gat_pkg::wh_rec_t   exp_wh_q[$];
  int                 wh_due_q[$];
  gat_pkg::coef_rec_t exp_coef_q[$];
  int                 coef_due_q[$];

  int cyc;
  int errs;
  int tests_ok;
  int tests_bad;
  int test_start;
  bit seen_pos;
  bit seen_neg;

  clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_coef_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_stb_i  (wgt_stb_i),
    .wgt_data_i (wgt_data_i),
    .h_stb_i    (h_stb_i),
    .h_i        (h_i),
    .w_rdy_o    (w_rdy_o),
    .wh_stb_o   (wh_stb_o),
    .wh_o       (wh_o),
    .coef_stb_o (coef_stb_o),
    .coef_o     (coef_o)
  );

  // Output checker against the expected queues
  always @(posedge clk) begin
    if (wh_due_q.size() > 0 && wh_due_q[0] < cyc) begin
      $display("Wh record due in cycle %0d never arrived", wh_due_q[0]);
      errs++;
      void'(wh_due_q.pop_front());
      void'(exp_wh_q.pop_front());
    end
    if (wh_stb_o) begin
      if (wh_due_q.size() == 0) begin
        $display("Unexpected Wh strobe at time %0t", $time);
        errs++;
      end else begin
        assert (wh_due_q[0] == cyc) else begin
          $display("Wh strobe at time %0t came in the wrong cycle", $time);
          errs++;
        end
        assert (wh_o == exp_wh_q[0]) else begin
          $display("FAILED at %0t: wh_o expected %h got %h", $time, exp_wh_q[0], wh_o);
          errs++;
        end
        void'(wh_due_q.pop_front());
        void'(exp_wh_q.pop_front());
      end
    end
    if (coef_due_q.size() > 0 && coef_due_q[0] < cyc) begin
      $display("Score due in cycle %0d never arrived", coef_due_q[0]);
      errs++;
      void'(coef_due_q.pop_front());
      void'(exp_coef_q.pop_front());
    end
    if (coef_stb_o) begin
      if (coef_due_q.size() == 0) begin
        $display("Unexpected score strobe at time %0t", $time);
        errs++;
      end else begin
        assert (coef_due_q[0] == cyc) else begin
          $display("Score strobe at time %0t came in the wrong cycle", $time);
          errs++;
        end
        assert (coef_o == exp_coef_q[0]) else begin
          $display("FAILED at %0t: coef_o expected %h got %h", $time, exp_coef_q[0], coef_o);
          errs++;
        end
        if (coef_o.score < 0) seen_neg = 1'b1;
        if (coef_o.score > 0) seen_pos = 1'b1;
        void'(coef_due_q.pop_front());
        void'(exp_coef_q.pop_front());
      end
    end
    cyc = cyc + 1;
  end

  function automatic int rand_weight();
    // Biased toward negative values
    return int'($urandom_range(0, 200)) - 128;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      h_stb_i   = 1'b0;
      wgt_stb_i = 1'b0;
    end
  endtask

  task automatic drive_beat(input gat_pkg::h_beat_t b);
    @(negedge clk);
    h_stb_i = 1'b1;
    h_i     = b;
  endtask

  // Expected Wh record and score for one row
  task automatic push_expect(input int wh[gat_pkg::NUM_FEAT_OUT], input bit tgt,
                             input int nn, input int drv_cyc);
    gat_pkg::wh_rec_t   rec;
    gat_pkg::coef_rec_t crec;
    int l;
    int r;
    int e;
    l = 0;
    r = 0;
    for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
      rec.wh[f] = wh[f][gat_pkg::WH_DATA_W-1:0];
      l += a_l[f] * wh[f];
      r += a_r[f] * wh[f];
    end
    rec.is_target = tgt;
    rec.num_nodes = nn[gat_pkg::NUM_NODE_W-1:0];
    if (tgt) begin
      mdl_left = l;
      mdl_sg++;
      mdl_node = 0;
    end else begin
      mdl_node++;
    end
    e = mdl_left + r;
    if (e < 0) e = e >>> gat_pkg::LEAKY_SHIFT;
    crec.score    = e;
    crec.subgraph = mdl_sg[gat_pkg::SUBGRAPH_W-1:0];
    crec.node     = mdl_node[gat_pkg::NUM_NODE_W-1:0];
    exp_wh_q.push_back(rec);
    wh_due_q.push_back(drv_cyc + 1);
    exp_coef_q.push_back(crec);
    coef_due_q.push_back(drv_cyc + 3);
  endtask

  task automatic send_row(input bit tgt, input int nn, input int len, input bit gaps,
                          input bit expect_out);
    gat_pkg::h_beat_t b;
    int wh[gat_pkg::NUM_FEAT_OUT];
    int col;
    int val;
    for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) wh[f] = 0;
    b = '0;
    b.is_hdr             = 1'b1;
    b.word.hdr.is_target = tgt;
    b.word.hdr.num_nodes = nn[gat_pkg::NUM_NODE_W-1:0];
    b.word.hdr.row_len   = len[gat_pkg::ROW_LEN_W-1:0];
    drive_beat(b);
    for (int k = 0; k < len; k++) begin
      if (gaps && $urandom_range(0, 1) == 1) idle(1);
      col = int'($urandom_range(0, gat_pkg::NUM_FEAT_IN - 1));
      val = rand_weight();
      b = '0;
      b.word.nz.col = col[gat_pkg::COL_IDX_W-1:0];
      b.word.nz.val = val[gat_pkg::DATA_W-1:0];
      drive_beat(b);
      for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) wh[f] += val * w_m[col][f];
    end
    if (expect_out) push_expect(wh, tgt, nn, cyc);
  endtask

  task automatic send_subgraph(input int nodes, input int max_len, input bit gaps);
    for (int n = 0; n < nodes; n++) begin
      send_row(n == 0, nodes, int'($urandom_range(0, max_len)), gaps, 1'b1);
    end
  endtask

  task automatic drain();
    int t;
    t = 0;
    // Drop the strobe of the last beat
    idle(1);
    while ((wh_due_q.size() > 0 || coef_due_q.size() > 0) && t < 50) begin
      @(negedge clk);
      t++;
    end
    if (t >= 50) begin
      $display("Timed out waiting for expected outputs to drain");
      errs++;
    end
    idle(3);
  endtask

  task automatic end_test(input string name);
    if (errs == test_start) begin
      $display("Test %s: passed", name);
      tests_ok++;
    end else begin
      $display("Test %s: failed with %0d errors", name, errs - test_start);
      tests_bad++;
    end
    test_start = errs;
  endtask

  initial begin
    int t;
    int v;
    wgt_stb_i  = 1'b0;
    wgt_data_i = '0;
    h_stb_i    = 1'b0;
    h_i        = '0;
    cyc        = 0;
    errs       = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    test_start = 0;
    mdl_left   = 0;
    mdl_sg     = -1;
    mdl_node   = 0;
    seen_pos   = 1'b0;
    seen_neg   = 1'b0;
    void'($urandom(97646));

    t = 0;
    while (rst_n !== 1'b1 && t < 100) begin
      @(negedge clk);
      t++;
    end
    if (t >= 100) begin
      $display("Reset was never released");
      errs++;
    end
    idle(1);

    // H beats before the weights are loaded must vanish
    send_row(1'b1, 2, 3, 1'b0, 1'b0);
    send_row(1'b1, 1, 0, 1'b0, 1'b0);
    idle(6);
    end_test("gating");

    for (int k = 0; k < gat_pkg::W_WORDS + gat_pkg::A_WORDS; k++) begin
      @(negedge clk);
      assert (w_rdy_o == 1'b0) else begin
        $display("FAILED at %0t: w_rdy_o expected 0 got %b", $time, w_rdy_o);
        errs++;
      end
      v = rand_weight();
      if (k < gat_pkg::W_WORDS) w_m[k / gat_pkg::NUM_FEAT_OUT][k % gat_pkg::NUM_FEAT_OUT] = v;
      else if (k < gat_pkg::W_WORDS + gat_pkg::NUM_FEAT_OUT) a_l[k - gat_pkg::W_WORDS] = v;
      else a_r[k - gat_pkg::W_WORDS - gat_pkg::NUM_FEAT_OUT] = v;
      wgt_stb_i  = 1'b1;
      wgt_data_i = v[gat_pkg::DATA_W-1:0];
    end
    @(negedge clk);
    wgt_stb_i  = 1'b1;
    wgt_data_i = 8'sd5;
    assert (w_rdy_o == 1'b1) else begin
      $display("FAILED at %0t: w_rdy_o expected 1 got %b", $time, w_rdy_o);
      errs++;
    end
    idle(2);
    end_test("ready");

    send_row(1'b1, 3, 4, 1'b1, 1'b1);
    send_row(1'b0, 3, 0, 1'b0, 1'b1);
    send_row(1'b0, 3, 16, 1'b1, 1'b1);
    drain();
    end_test("wh_values");

    for (int s = 0; s < 12; s++) begin
      send_subgraph(int'($urandom_range(1, gat_pkg::MAX_NODES)), 6, 1'b1);
    end
    drain();
    if (!(seen_pos && seen_neg)) begin
      $display("Scores did not reach both signs");
      errs++;
    end
    end_test("scores");

    for (int s = 0; s < 4; s++) send_subgraph(gat_pkg::MAX_NODES, 2, 1'b0);
    // Single-entry rows then empty rows, Wh strobes on consecutive cycles
    for (int n = 0; n < 6; n++) send_row(n == 0, 6, (n % 3 == 0) ? 1 : 0, 1'b0, 1'b1);
    drain();
    end_test("back_to_back");

    $display("Tests passed: %0d, failed: %0d, check errors: %0d", tests_ok, tests_bad, errs);
    if (errs == 0 && tests_bad == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    repeat (20000) @(posedge clk);
    $display("Simulation timed out");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
logic/gat_pkg.sv
logic/weight_store.sv
logic/spmm_row.sv
logic/attn_coef.sv
logic/gat_coef_top.sv
sim/clk_gen.sv
sim/gat_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module gat_tb -f files.f -o gat_sim \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/gat_sim > sim.log 2>&1
cat sim.log
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
